// ==== rtl/mshr_ack_merge.sv ====
/*
 * Hit and acknowledge data come from the registered way reads, one cycle
 * after the command. empty_o and full_o follow the live valid flags.
 */
module mshr_ack_merge
    import mshr_geom_pkg::*, mshr_entry_pkg::*;
(
    input  mshr_tag_t               check_tag_i,
    input  mshr_set_t               ack_set_i,
    input  mshr_way_t               ack_way_i,

    output logic                    hit_o,

    output req_tid_t                ack_tid_o,
    output req_sid_t                ack_sid_o,
    output word_idx_t               ack_word_o,
    output logic                    ack_need_rsp_o,
    output logic                    ack_is_prefetch_o,
    output nline_u                  ack_nline_o,
    output logic [CACHE_SET_W-1:0]  ack_cache_set_o,

    output logic                    empty_o,
    output logic                    full_o,

    mshr_way_if.merge               ways [MSHR_WAYS]
);

    logic [MSHR_WAYS-1:0][MSHR_SETS-1:0] valid_vec;
    mshr_entry_t [MSHR_WAYS-1:0]         rentry;
    logic [MSHR_WAYS-1:0]                hit_way;
    mshr_entry_t                         ack_entry;
    nline_u                              ack_line;

    for (genvar w = 0; w < MSHR_WAYS; w++) begin : g_way
        assign valid_vec[w] = ways[w].valid_vec;
        assign rentry[w]    = ways[w].rentry;
        // Way holds the checked line if its read slot was live and tags agree
        assign hit_way[w]   = ways[w].rvalid & (ways[w].rentry.tag == check_tag_i);
    end

    assign hit_o = |hit_way;

    // Acknowledged entry
    assign ack_entry = rentry[ack_way_i];

    assign ack_tid_o         = ack_entry.tid;
    assign ack_sid_o         = ack_entry.sid;
    assign ack_word_o        = ack_entry.word_idx;
    assign ack_need_rsp_o    = ack_entry.need_rsp;
    assign ack_is_prefetch_o = ack_entry.is_prefetch;

    // Rebuild the line from stored tag and slot set
    always_comb begin
        ack_line.mshr.tag = ack_entry.tag;
        ack_line.mshr.set = ack_set_i;
    end

    assign ack_nline_o     = ack_line;
    // Same word seen through the data cache split
    assign ack_cache_set_o = ack_line.cache.set;

    assign empty_o = ~|valid_vec;
    assign full_o  = &valid_vec;

endmodule

// ==== rtl/mshr_alloc_ctrl.sv ====
/*
 * Commands are single-cycle strobes. An acknowledge never coincides with a
 * check or allocation. An allocation into a full set is silently dropped.
 */
module mshr_alloc_ctrl
    import mshr_geom_pkg::*, mshr_entry_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_ni,

    input  logic       check_i,
    input  nline_u     check_nline_i,

    input  logic       alloc_i,
    input  nline_u     alloc_nline_i,
    input  req_tid_t   alloc_tid_i,
    input  req_sid_t   alloc_sid_i,
    input  word_idx_t  alloc_word_i,
    input  logic       alloc_need_rsp_i,
    input  logic       alloc_is_prefetch_i,
    output logic       alloc_full_o,
    output mshr_way_t  alloc_way_o,

    input  logic       ack_i,
    input  mshr_set_t  ack_set_i,
    input  mshr_way_t  ack_way_i,

    output mshr_tag_t  check_tag_o,
    output mshr_set_t  ack_set_o,
    output mshr_way_t  ack_way_o,

    mshr_way_if.ctrl   ways [MSHR_WAYS]
);

    logic [MSHR_WAYS-1:0][MSHR_SETS-1:0] valid_vec;
    logic [MSHR_WAYS-1:0]                we_way;
    logic [MSHR_WAYS-1:0]                clr_way;
    logic [MSHR_WAYS-1:0]                rd_way;

    logic        check;
    mshr_set_t   alloc_set;
    mshr_set_t   shared_addr;
    mshr_entry_t alloc_entry;
    logic        free_found;
    mshr_way_t   free_way;
    logic        check_set_full;

    mshr_tag_t   check_tag_q;
    mshr_set_t   check_set_q;
    mshr_set_t   ack_set_q;
    mshr_way_t   ack_way_q;

    // Allocation wins over a check in the same cycle
    assign check     = check_i & ~alloc_i;
    assign alloc_set = alloc_nline_i.mshr.set;

    assign shared_addr = ack_i   ? ack_set_i :
                         alloc_i ? alloc_set : check_nline_i.mshr.set;

    // Lowest free way of the allocation set, way 0 when none
    always_comb begin
        free_found = 1'b0;
        free_way   = '0;
        for (int w = 0; w < MSHR_WAYS; w++) begin
            if (!free_found && !valid_vec[w][alloc_set]) begin
                free_found = 1'b1;
                free_way   = mshr_way_t'(w);
            end
        end
    end

    assign alloc_way_o = free_way;

    // Room left in the set of the last check
    always_comb begin
        check_set_full = 1'b1;
        for (int w = 0; w < MSHR_WAYS; w++) begin
            check_set_full = check_set_full & valid_vec[w][check_set_q];
        end
    end

    assign alloc_full_o = check_set_full;

    assign alloc_entry = '{
        tag:         alloc_nline_i.mshr.tag,
        tid:         alloc_tid_i,
        sid:         alloc_sid_i,
        word_idx:    alloc_word_i,
        need_rsp:    alloc_need_rsp_i,
        is_prefetch: alloc_is_prefetch_i
    };

    for (genvar w = 0; w < MSHR_WAYS; w++) begin : g_way
        // A check reads every way, an acknowledge only the freed one
        assign we_way[w]  = alloc_i & free_found & (free_way == mshr_way_t'(w));
        assign clr_way[w] = ack_i & (ack_way_i == mshr_way_t'(w));
        assign rd_way[w]  = check | clr_way[w];

        assign valid_vec[w]    = ways[w].valid_vec;
        assign ways[w].we      = we_way[w];
        assign ways[w].clr     = clr_way[w];
        assign ways[w].rd      = rd_way[w];
        assign ways[w].addr    = shared_addr;
        assign ways[w].wentry  = alloc_entry;
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            check_tag_q <= '0;
            check_set_q <= '0;
            ack_set_q   <= '0;
            ack_way_q   <= '0;
        end else begin
            if (check) begin
                check_tag_q <= check_nline_i.mshr.tag;
                check_set_q <= check_nline_i.mshr.set;
            end
            if (ack_i) begin
                ack_set_q <= ack_set_i;
                ack_way_q <= ack_way_i;
            end
        end
    end

    assign check_tag_o = check_tag_q;
    assign ack_set_o   = ack_set_q;
    assign ack_way_o   = ack_way_q;

endmodule

// ==== rtl/mshr_entry_pkg.sv ====
/*
 * Request identifiers and the entry stored per MSHR slot (25 bits).
 * The entry keeps the full MSHR tag; the set is implied by the slot.
 */
package mshr_entry_pkg;

    import mshr_geom_pkg::*;

    // Transaction id returned with the refill response
    typedef logic [3:0] req_tid_t;

    // Requesting source port
    typedef logic [1:0] req_sid_t;

    // Word within the line that the requester is waiting for
    typedef logic [2:0] word_idx_t;

    typedef struct packed {
        mshr_tag_t tag;
        req_tid_t  tid;
        req_sid_t  sid;
        word_idx_t word_idx;
        // Requester expects a response for this miss
        logic      need_rsp;
        // Miss was raised by the prefetcher
        logic      is_prefetch;
    } mshr_entry_t;

endpackage

// ==== rtl/mshr_geom_pkg.sv ====
/*
 * MSHR geometry: 4 sets of 4 ways over a 16-bit line address.
 * The data cache splits the same line address as 10-bit tag over 6-bit set.
 */
package mshr_geom_pkg;

    // MSHR organisation
    localparam int unsigned MSHR_SETS  = 4;
    localparam int unsigned MSHR_WAYS  = 4;
    localparam int unsigned MSHR_SET_W = 2;
    localparam int unsigned MSHR_WAY_W = 2;

    // Line address, i.e. byte address without the line offset
    localparam int unsigned NLINE_W = 16;

    // MSHR tag is everything above the MSHR set
    localparam int unsigned MSHR_TAG_W = NLINE_W - MSHR_SET_W;

    // Split used by the data cache itself
    localparam int unsigned CACHE_SET_W = 6;
    localparam int unsigned CACHE_TAG_W = NLINE_W - CACHE_SET_W;

    typedef logic [MSHR_SET_W-1:0] mshr_set_t;
    typedef logic [MSHR_WAY_W-1:0] mshr_way_t;
    typedef logic [MSHR_TAG_W-1:0] mshr_tag_t;

    // MSHR view of a line address
    typedef struct packed {
        mshr_tag_t tag;
        mshr_set_t set;
    } nline_mshr_t;

    // Data cache view of the same line address
    typedef struct packed {
        logic [CACHE_TAG_W-1:0] tag;
        logic [CACHE_SET_W-1:0] set;
    } nline_cache_t;

    // One line address, decoded either way
    // Both views are NLINE_W bits wide and share the low bits
    typedef union packed {
        nline_mshr_t  mshr;
        nline_cache_t cache;
    } nline_u;

endpackage

// ==== rtl/mshr_top.sv ====
/*
 * MSHR of a non-blocking data cache, 4 sets by 4 ways, no back-pressure.
 * Requester must look at alloc_full_o before allocating.
 */
module mshr_top
    import mshr_geom_pkg::*, mshr_entry_pkg::*;
(
    input  logic                    clk_i,
    input  logic                    rst_ni,

    // Check
    input  logic                    check_i,
    input  nline_u                  check_nline_i,
    output logic                    hit_o,

    // Allocation
    input  logic                    alloc_i,
    input  nline_u                  alloc_nline_i,
    input  req_tid_t                alloc_tid_i,
    input  req_sid_t                alloc_sid_i,
    input  word_idx_t               alloc_word_i,
    input  logic                    alloc_need_rsp_i,
    input  logic                    alloc_is_prefetch_i,
    output logic                    alloc_full_o,
    output mshr_way_t               alloc_way_o,

    // Acknowledge
    input  logic                    ack_i,
    input  mshr_set_t               ack_set_i,
    input  mshr_way_t               ack_way_i,
    output req_tid_t                ack_tid_o,
    output req_sid_t                ack_sid_o,
    output word_idx_t               ack_word_o,
    output logic                    ack_need_rsp_o,
    output logic                    ack_is_prefetch_o,
    output nline_u                  ack_nline_o,
    output logic [CACHE_SET_W-1:0]  ack_cache_set_o,

    // Global
    output logic                    empty_o,
    output logic                    full_o
);

    mshr_tag_t check_tag_q;
    mshr_set_t ack_set_q;
    mshr_way_t ack_way_q;

    mshr_way_if way_if [MSHR_WAYS] ();

    mshr_alloc_ctrl alloc_ctrl_i (
        .clk_i               (clk_i),
        .rst_ni              (rst_ni),
        .check_i             (check_i),
        .check_nline_i       (check_nline_i),
        .alloc_i             (alloc_i),
        .alloc_nline_i       (alloc_nline_i),
        .alloc_tid_i         (alloc_tid_i),
        .alloc_sid_i         (alloc_sid_i),
        .alloc_word_i        (alloc_word_i),
        .alloc_need_rsp_i    (alloc_need_rsp_i),
        .alloc_is_prefetch_i (alloc_is_prefetch_i),
        .alloc_full_o        (alloc_full_o),
        .alloc_way_o         (alloc_way_o),
        .ack_i               (ack_i),
        .ack_set_i           (ack_set_i),
        .ack_way_i           (ack_way_i),
        .check_tag_o         (check_tag_q),
        .ack_set_o           (ack_set_q),
        .ack_way_o           (ack_way_q),
        .ways                (way_if)
    );

    for (genvar w = 0; w < MSHR_WAYS; w++) begin : g_way
        mshr_way way_i (
            .clk_i  (clk_i),
            .rst_ni (rst_ni),
            .port   (way_if[w])
        );
    end

    mshr_ack_merge ack_merge_i (
        .check_tag_i       (check_tag_q),
        .ack_set_i         (ack_set_q),
        .ack_way_i         (ack_way_q),
        .hit_o             (hit_o),
        .ack_tid_o         (ack_tid_o),
        .ack_sid_o         (ack_sid_o),
        .ack_word_o        (ack_word_o),
        .ack_need_rsp_o    (ack_need_rsp_o),
        .ack_is_prefetch_o (ack_is_prefetch_o),
        .ack_nline_o       (ack_nline_o),
        .ack_cache_set_o   (ack_cache_set_o),
        .empty_o           (empty_o),
        .full_o            (full_o),
        .ways              (way_if)
    );

endmodule

// ==== rtl/mshr_way.sv ====
/*
 * One MSHR way: a valid flag and an entry per set, one shared address.
 * The read port is registered and holds its data until the next read.
 */
module mshr_way
    import mshr_geom_pkg::*, mshr_entry_pkg::*;
(
    input  logic    clk_i,
    input  logic    rst_ni,
    mshr_way_if.way port
);

    logic [MSHR_SETS-1:0] valid_q;
    mshr_entry_t          entry_q [MSHR_SETS];
    mshr_entry_t          rentry_q;
    logic                 rvalid_q;

    // Valid flags and read flag
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q  <= '0;
            rvalid_q <= 1'b0;
        end else begin
            if (port.we) begin
                valid_q[port.addr] <= 1'b1;
            end
            if (port.clr) begin
                valid_q[port.addr] <= 1'b0;
            end
            // A read that frees the slot sees it as no longer pending,
            // so the freed line stops hitting
            if (port.rd) begin
                rvalid_q <= valid_q[port.addr] & ~port.clr;
            end
        end
    end

    // Entry storage and read data
    always_ff @(posedge clk_i) begin
        if (port.we) begin
            entry_q[port.addr] <= port.wentry;
        end
        if (port.rd) begin
            rentry_q <= entry_q[port.addr];
        end
    end

    assign port.valid_vec = valid_q;
    assign port.rentry    = rentry_q;
    assign port.rvalid    = rvalid_q;

endmodule

// ==== rtl/mshr_way_if.sv ====
/*
 * Link between the front end, one MSHR way and the merge block.
 * addr is shared by read and write; only one command is active per cycle.
 */
interface mshr_way_if
    import mshr_geom_pkg::*, mshr_entry_pkg::*;
();

    // Front end to way
    logic        we;
    logic        clr;
    mshr_set_t   addr;
    mshr_entry_t wentry;
    logic        rd;

    // Way back to front end and merge block
    logic [MSHR_SETS-1:0] valid_vec;
    mshr_entry_t          rentry;
    logic                 rvalid;

    // Front end also watches the live valid flags for the free-way search
    modport ctrl (
        output we,
        output clr,
        output addr,
        output wentry,
        output rd,
        input  valid_vec
    );

    modport way (
        input  we,
        input  clr,
        input  addr,
        input  wentry,
        input  rd,
        output valid_vec,
        output rentry,
        output rvalid
    );

    modport merge (
        input  valid_vec,
        input  rentry,
        input  rvalid
    );

endinterface

// ==== src.f ====
rtl/mshr_geom_pkg.sv
rtl/mshr_entry_pkg.sv
rtl/mshr_way_if.sv
rtl/mshr_alloc_ctrl.sv
rtl/mshr_way.sv
rtl/mshr_ack_merge.sv
rtl/mshr_top.sv
testbench/mshr_tb.sv

// ==== testbench/mshr_golden.txt ====
# op nline tid sid word rsp pf set way | expected way hit afull cset empty full (all hex)
# ack lines hold the expected readout in the nline to pf columns
idle  0000 0 0 0 0 0 0 0 0 0 0 00 1 0
check 1234 0 0 0 0 0 0 0 0 0 0 00 1 0
alloc 1234 5 1 3 1 0 0 0 0 0 0 00 0 0
check 1234 0 0 0 0 0 0 0 0 1 0 00 0 0
check 5674 0 0 0 0 0 0 0 0 0 0 00 0 0
alloc 2220 1 0 0 1 0 0 0 1 0 0 00 0 0
alloc 3330 2 2 6 0 1 0 0 2 0 0 00 0 0
alloc 4440 3 3 7 1 1 0 0 3 0 0 00 0 0
check 2220 0 0 0 0 0 0 0 0 1 1 00 0 0
check 0e01 0 0 0 0 0 0 0 0 0 0 00 0 0
alloc 0f00 f 0 0 0 0 0 0 0 0 0 00 0 0
ack   3330 2 2 6 0 1 0 2 0 0 0 30 0 0
check 3330 0 0 0 0 0 0 0 0 0 0 00 0 0
alloc 5550 6 1 1 1 0 0 0 2 0 0 00 0 0
alloc 0a01 7 0 2 1 0 0 0 0 0 0 00 0 0
alloc 0b45 8 1 4 0 0 0 0 1 0 0 00 0 0
alloc c389 9 2 5 1 1 0 0 2 0 0 00 0 0
alloc fffd a 3 7 0 1 0 0 3 0 0 00 0 0
alloc 1002 b 0 1 1 0 0 0 0 0 0 00 0 0
alloc 2106 c 1 3 1 0 0 0 1 0 0 00 0 0
alloc 804a d 2 0 0 1 0 0 2 0 0 00 0 0
alloc 7ffe e 3 6 1 1 0 0 3 0 0 00 0 0
alloc 0003 f 0 2 0 0 0 0 0 0 0 00 0 0
alloc abc7 0 1 5 1 0 0 0 1 0 0 00 0 0
alloc 5a5b 4 2 4 1 1 0 0 2 0 0 00 0 0
alloc ffff 1 3 1 0 0 0 0 3 0 0 00 0 1
ack   1234 5 1 3 1 0 0 0 0 0 0 34 0 0
ack   2220 1 0 0 1 0 0 1 0 0 0 20 0 0
ack   5550 6 1 1 1 0 0 2 0 0 0 10 0 0
ack   4440 3 3 7 1 1 0 3 0 0 0 00 0 0
ack   0a01 7 0 2 1 0 1 0 0 0 0 01 0 0
ack   0b45 8 1 4 0 0 1 1 0 0 0 05 0 0
ack   c389 9 2 5 1 1 1 2 0 0 0 09 0 0
ack   fffd a 3 7 0 1 1 3 0 0 0 3d 0 0
ack   1002 b 0 1 1 0 2 0 0 0 0 02 0 0
ack   2106 c 1 3 1 0 2 1 0 0 0 06 0 0
ack   804a d 2 0 0 1 2 2 0 0 0 0a 0 0
ack   7ffe e 3 6 1 1 2 3 0 0 0 3e 0 0
ack   0003 f 0 2 0 0 3 0 0 0 0 03 0 0
ack   abc7 0 1 5 1 0 3 1 0 0 0 07 0 0
ack   5a5b 4 2 4 1 1 3 2 0 0 0 1b 0 0
ack   ffff 1 3 1 0 0 3 3 0 0 0 3f 1 0

// ==== testbench/mshr_tb.sv ====
/*
 * Drives mshr_top from testbench/mshr_golden.txt, one command per clock.
 * Must run from the project root so that the golden file path resolves.
 */
module mshr_tb
    import mshr_geom_pkg::*, mshr_entry_pkg::*;
();

    localparam int unsigned CLK_PERIOD = 100;
    localparam int unsigned RST_CYCLES = 8;
    localparam int unsigned MAX_VECS   = 64;

    // One golden line with its stimulus and expected values
    typedef struct packed {
        logic [63:0]            op;
        logic [NLINE_W-1:0]     nline;
        req_tid_t               tid;
        req_sid_t               sid;
        word_idx_t              word;
        logic                   need_rsp;
        logic                   is_prefetch;
        mshr_set_t              set;
        mshr_way_t              way;
        mshr_way_t              exp_way;
        logic                   exp_hit;
        logic                   exp_afull;
        logic [CACHE_SET_W-1:0] exp_cset;
        logic                   exp_empty;
        logic                   exp_full;
    } golden_t;

    logic                   clk_i;
    logic                   rst_ni;
    logic                   check_i;
    nline_u                 check_nline_i;
    logic                   hit_o;
    logic                   alloc_i;
    nline_u                 alloc_nline_i;
    req_tid_t               alloc_tid_i;
    req_sid_t               alloc_sid_i;
    word_idx_t              alloc_word_i;
    logic                   alloc_need_rsp_i;
    logic                   alloc_is_prefetch_i;
    logic                   alloc_full_o;
    mshr_way_t              alloc_way_o;
    logic                   ack_i;
    mshr_set_t              ack_set_i;
    mshr_way_t              ack_way_i;
    req_tid_t               ack_tid_o;
    req_sid_t               ack_sid_o;
    word_idx_t              ack_word_o;
    logic                   ack_need_rsp_o;
    logic                   ack_is_prefetch_o;
    nline_u                 ack_nline_o;
    logic [CACHE_SET_W-1:0] ack_cache_set_o;
    logic                   empty_o;
    logic                   full_o;

    golden_t vecs [MAX_VECS];
    int      n_vecs = 0;
    int      errors = 0;
    logic    loaded = 1'b0;

    mshr_top mshr_top_i (.*);

    initial clk_i = 1'b0;
    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp, input int idx);
        assert (got === exp)
        else begin
            $display("Error: %s = 0x%0h, expected 0x%0h (vector %0d)", name, got, exp, idx);
            errors++;
        end
    endtask

    task automatic drive_idle();
        check_i             = 1'b0;
        check_nline_i       = '0;
        alloc_i             = 1'b0;
        alloc_nline_i       = '0;
        alloc_tid_i         = '0;
        alloc_sid_i         = '0;
        alloc_word_i        = '0;
        alloc_need_rsp_i    = 1'b0;
        alloc_is_prefetch_i = 1'b0;
        ack_i               = 1'b0;
        ack_set_i           = '0;
        ack_way_i           = '0;
    endtask

    task automatic apply_vector(input golden_t v, input int idx);
        drive_idle();
        case (v.op)
            "idle": ;
            "check": begin
                check_i       = 1'b1;
                check_nline_i = v.nline;
            end
            "alloc": begin
                alloc_i             = 1'b1;
                alloc_nline_i       = v.nline;
                alloc_tid_i         = v.tid;
                alloc_sid_i         = v.sid;
                alloc_word_i        = v.word;
                alloc_need_rsp_i    = v.need_rsp;
                alloc_is_prefetch_i = v.is_prefetch;
            end
            "ack": begin
                ack_i     = 1'b1;
                ack_set_i = v.set;
                ack_way_i = v.way;
            end
            default: begin
                $display("Golden vector %0d has an unknown command", idx);
                errors++;
            end
        endcase
    endtask

    // Registered results of the command issued one cycle earlier
    task automatic check_results(input golden_t v, input int idx);
        if (v.op == "check") begin
            check_value("hit_o", hit_o, v.exp_hit, idx);
            check_value("alloc_full_o", alloc_full_o, v.exp_afull, idx);
        end
        if (v.op == "ack") begin
            check_value("ack_tid_o", ack_tid_o, v.tid, idx);
            check_value("ack_sid_o", ack_sid_o, v.sid, idx);
            check_value("ack_word_o", ack_word_o, v.word, idx);
            check_value("ack_need_rsp_o", ack_need_rsp_o, v.need_rsp, idx);
            check_value("ack_is_prefetch_o", ack_is_prefetch_o, v.is_prefetch, idx);
            check_value("ack_nline_o", ack_nline_o, v.nline, idx);
            check_value("ack_cache_set_o", ack_cache_set_o, v.exp_cset, idx);
        end
        check_value("empty_o", empty_o, v.exp_empty, idx);
        check_value("full_o", full_o, v.exp_full, idx);
    endtask

    task automatic load_golden();
        int               fd;
        int               got;
        logic [63:0]      op_word;
        logic [31:0]      f [14];
        logic [8*256-1:0] rest;
        golden_t          v;
        fd = $fopen("testbench/mshr_golden.txt", "r");
        if (fd == 0) begin
            $display("Could not open testbench/mshr_golden.txt");
            errors++;
            return;
        end
        while (n_vecs < MAX_VECS) begin
            op_word = '0;
            got = $fscanf(fd, "%s", op_word);
            if (got != 1) begin
                break;
            end
            if (op_word == "#") begin
                got = $fgets(rest, fd);
            end else begin
                got = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                              f[0], f[1], f[2], f[3], f[4], f[5], f[6],
                              f[7], f[8], f[9], f[10], f[11], f[12], f[13]);
                if (got != 14) begin
                    $display("Golden line for vector %0d is incomplete", n_vecs);
                    errors++;
                    break;
                end
                v.op          = op_word;
                v.nline       = f[0][NLINE_W-1:0];
                v.tid         = f[1][3:0];
                v.sid         = f[2][1:0];
                v.word        = f[3][2:0];
                v.need_rsp    = f[4][0];
                v.is_prefetch = f[5][0];
                v.set         = f[6][MSHR_SET_W-1:0];
                v.way         = f[7][MSHR_WAY_W-1:0];
                v.exp_way     = f[8][MSHR_WAY_W-1:0];
                v.exp_hit     = f[9][0];
                v.exp_afull   = f[10][0];
                v.exp_cset    = f[11][CACHE_SET_W-1:0];
                v.exp_empty   = f[12][0];
                v.exp_full    = f[13][0];
                vecs[n_vecs]  = v;
                n_vecs++;
            end
        end
        $fclose(fd);
    endtask

    initial begin : watchdog
        wait (loaded);
        #((n_vecs + 20) * CLK_PERIOD);
        $display("Timeout: the run did not finish within %0d cycles", n_vecs + 20);
        $display("Testbench failed");
        $finish;
    end

    initial begin : main
        rst_ni = 1'b0;
        drive_idle();
        load_golden();
        loaded = 1'b1;
        repeat (RST_CYCLES) @(negedge clk_i);
        rst_ni = 1'b1;
        for (int i = 0; i < n_vecs; i++) begin
            @(negedge clk_i);
            if (i > 0) begin
                check_results(vecs[i-1], i - 1);
            end
            apply_vector(vecs[i], i);
            // Free way is combinational, so sample it before the rising edge
            #(CLK_PERIOD / 4);
            if (vecs[i].op == "alloc") begin
                check_value("alloc_way_o", alloc_way_o, vecs[i].exp_way, i);
            end
        end
        @(negedge clk_i);
        if (n_vecs > 0) begin
            check_results(vecs[n_vecs-1], n_vecs - 1);
        end
        drive_idle();
        $display("%0d golden vectors run, %0d errors", n_vecs, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule
